/* logic/trig_pkg.sv */
package trig_pkg;

	// marker word and status width
	localparam int word_width = 8;

	// fixed marker words, sent in rotation, msb always set
	localparam logic [word_width-1:0] marker_first  = 8'b11110000;
	localparam logic [word_width-1:0] marker_second = 8'b10000001;
	localparam logic [word_width-1:0] marker_third  = 8'b10001000;
	localparam logic [word_width-1:0] marker_fourth = 8'b10101010;

	// rotation state of the sequencer
	typedef enum logic [1:0] {
		tok_first  = 2'b00,
		tok_second = 2'b01,
		tok_third  = 2'b10,
		tok_fourth = 2'b11
	} token_t;

	// where trigger events come from
	typedef enum logic {
		mode_external = 1'b0,
		mode_self     = 1'b1
	} mode_t;

	// serializer queue depth, also the credit count after reset
	localparam int credit_depth    = 2;
	localparam int credit_width    = $clog2(credit_depth + 1);
	localparam int queue_ptr_width = $clog2(credit_depth);

	// bits still to go out of the shifter, 0 means idle
	localparam int bit_count_width = $clog2(word_width + 1);

	// internal tick every 2**6 = 64 cycles
	localparam int self_period_log2 = 6;

	// power-on stretch after reset1 drops
	localparam int reset_hold_cycles = 16;
	localparam int reset_count_width = $clog2(reset_hold_cycles + 1);

	// saturating count of dropped triggers
	localparam int missed_width = 8;

endpackage

/* logic/power_on_reset.sv */
`timescale 1ns/100ps

module power_on_reset (
	input  logic clock,
	input  logic reset1,
	output logic core_reset
);
	import trig_pkg::*;

	logic [reset_count_width-1:0] hold_count;

	// restart on reset1, then count up once and stay
	always_ff @(posedge clock) begin
		if (reset1) begin
			hold_count <= '0;
		end else if (hold_count != reset_count_width'(reset_hold_cycles)) begin
			hold_count <= hold_count + 1'b1;
		end
	end

	// released only once the count is reached
	assign core_reset = reset1 || (hold_count != reset_count_width'(reset_hold_cycles));

	// the core stays in reset with reset1 and for the full stretch after it
	reset_stretch_a: assert property (
		@(posedge clock) reset1 |-> core_reset ##1 core_reset [*reset_hold_cycles]
	) else $error("core_reset released early after reset1");

endmodule

/* logic/trigger_edge_detect.sv */
`timescale 1ns/100ps

module trigger_edge_detect (
	input  logic clock,
	input  logic core_reset,
	input  logic trigger_in,
	output logic trigger_edge
);

	// two-flop synchronizer for the async trigger line
	logic sync_stage1;
	logic sync_stage2;

	// last three synchronized samples, bit 2 is the oldest
	logic [2:0] sample_history;

	always_ff @(posedge clock) begin
		if (core_reset) begin
			sync_stage1    <= 1'b0;
			sync_stage2    <= 1'b0;
			sample_history <= 3'b000;
		end else begin
			sync_stage1    <= trigger_in;
			sync_stage2    <= sync_stage1;
			sample_history <= {sample_history[1:0], sync_stage2};
		end
	end

	// low, low, high: one pulse per rising edge, even when held high
	assign trigger_edge = (sample_history == 3'b001);

	// a held trigger must not retrigger
	single_pulse_a: assert property (
		@(posedge clock) disable iff (core_reset) trigger_edge |=> !trigger_edge
	) else $error("trigger_edge high for two cycles");

endmodule

/* logic/pattern_sequencer.sv */
`timescale 1ns/100ps

module pattern_sequencer (
	input  logic                              clock,
	input  logic                              core_reset,
	input  logic                              trigger_edge,
	input  logic                              self_trigger,
	input  logic                              credit_return,
	output logic                              word_valid,
	output logic                              sync,
	output logic [trig_pkg::word_width-1:0]   word_data,
	output logic [trig_pkg::word_width-1:0]   status_word,
	output logic [trig_pkg::missed_width-1:0] missed_count
);
	import trig_pkg::*;

	mode_t                       trigger_mode;
	token_t                      token;
	logic [self_period_log2-1:0] tick_count;
	logic                        tick_wrap;
	logic                        trigger_event;
	logic [credit_width-1:0]     credits;
	logic                        credit_free;
	logic                        issue;

	function automatic logic [word_width-1:0] marker_for(input token_t tok);
		case (tok)
			tok_first:  marker_for = marker_first;
			tok_second: marker_for = marker_second;
			tok_third:  marker_for = marker_third;
			default:    marker_for = marker_fourth;
		endcase
	endfunction

	assign trigger_mode = self_trigger ? mode_self : mode_external;

	// internal tick fires once per counter wrap
	assign tick_wrap = &tick_count;

	// in self mode the external edges are ignored
	always_comb begin
		case (trigger_mode)
			mode_self: trigger_event = tick_wrap;
			default:   trigger_event = trigger_edge;
		endcase
	end

	// a word_valid in flight already owns one of the counted credits
	assign credit_free = (credits > credit_width'(word_valid));
	assign issue       = trigger_event && credit_free;

	// spend on word_valid, refill on credit_return
	always_ff @(posedge clock) begin
		if (core_reset) begin
			credits <= credit_width'(credit_depth);
		end else begin
			case ({word_valid, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (core_reset) begin
			tick_count   <= '0;
			token        <= tok_first;
			word_valid   <= 1'b0;
			sync         <= 1'b0;
			status_word  <= '0;
			missed_count <= '0;
		end else begin
			tick_count <= tick_count + 1'b1;
			word_valid <= issue;
			if (issue) begin
				status_word <= marker_for(token);
				token       <= token_t'(token + 1'b1);
				// sync spans first word to second word
				if (token == tok_first) begin
					sync <= 1'b1;
				end else if (token == tok_second) begin
					sync <= 1'b0;
				end
			end else if (trigger_event && (missed_count != '1)) begin
				// no credit, so drop it and keep the token where it is
				missed_count <= missed_count + 1'b1;
			end
		end
	end

	// the issued word is held for both the serializer and the leds
	assign word_data = status_word;

	// returns from the serializer never exceed what was spent
	credits_bounded_a: assert property (
		@(posedge clock) disable iff (core_reset)
		credits <= credit_width'(credit_depth)
	) else $error("credit count above queue depth");

	no_valid_without_credit_a: assert property (
		@(posedge clock) disable iff (core_reset)
		word_valid |-> (credits != '0)
	) else $error("word_valid with no credit");

endmodule

/* logic/word_serializer.sv */
`timescale 1ns/100ps

module word_serializer (
	input  logic                            clock,
	input  logic                            core_reset,
	input  logic                            word_valid,
	input  logic [trig_pkg::word_width-1:0] word_data,
	output logic                            credit_return,
	output logic                            serial_out,
	output logic                            frame_mark
);
	import trig_pkg::*;

	// small word queue, one entry per credit
	logic [word_width-1:0]      queue_mem [credit_depth];
	logic [queue_ptr_width-1:0] wr_ptr;
	logic [queue_ptr_width-1:0] rd_ptr;
	logic [credit_width-1:0]    queue_count;

	// msb-first shifter
	logic [word_width-1:0]      shift_reg;
	logic [bit_count_width-1:0] bits_left;

	logic queue_empty;
	logic shifter_free;
	logic load;

	assign queue_empty  = (queue_count == '0);
	// free when idle or on the last bit, so queued words go back to back
	assign shifter_free = (bits_left == '0) || (bits_left == bit_count_width'(1));
	assign load         = !queue_empty && shifter_free;

	always_ff @(posedge clock) begin
		if (word_valid) begin
			queue_mem[wr_ptr] <= word_data;
		end
	end

	always_ff @(posedge clock) begin
		if (core_reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			queue_count <= '0;
		end else begin
			if (word_valid) begin
				wr_ptr <= (wr_ptr == queue_ptr_width'(credit_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (load) begin
				rd_ptr <= (rd_ptr == queue_ptr_width'(credit_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({word_valid, load})
				2'b10:   queue_count <= queue_count + 1'b1;
				2'b01:   queue_count <= queue_count - 1'b1;
				default: queue_count <= queue_count;
			endcase
		end
	end

	// shifting in zeros leaves the line low once a word is out
	always_ff @(posedge clock) begin
		if (core_reset) begin
			shift_reg     <= '0;
			bits_left     <= '0;
			credit_return <= 1'b0;
			frame_mark    <= 1'b0;
		end else begin
			credit_return <= load;
			frame_mark    <= load;
			if (load) begin
				shift_reg <= queue_mem[rd_ptr];
				bits_left <= bit_count_width'(word_width);
			end else if (bits_left != '0) begin
				shift_reg <= shift_reg << 1;
				bits_left <= bits_left - 1'b1;
			end
		end
	end

	assign serial_out = shift_reg[word_width-1];

	// the sequencer's credits keep the queue from overflowing
	no_write_when_full_a: assert property (
		@(posedge clock) disable iff (core_reset)
		word_valid |-> (queue_count < credit_width'(credit_depth))
	) else $error("word written into a full queue");

endmodule

/* logic/trigger_pattern_top.sv */
`timescale 1ns/100ps

module trigger_pattern_top (
	input  logic                              clock,
	input  logic                              reset1,
	input  logic                              trigger_in,
	input  logic                              self_trigger,
	output logic                              serial_out,
	output logic                              frame_mark,
	output logic [trig_pkg::word_width-1:0]   status_word,
	output logic                              sync,
	output logic [trig_pkg::missed_width-1:0] missed_count
);
	import trig_pkg::*;

	logic                  core_reset;
	logic                  trigger_edge;
	logic                  word_valid;
	logic [word_width-1:0] word_data;
	logic                  credit_return;

	power_on_reset power_on_reset_i (
		.clock      (clock),
		.reset1     (reset1),
		.core_reset (core_reset)
	);

	trigger_edge_detect trigger_edge_detect_i (
		.clock        (clock),
		.core_reset   (core_reset),
		.trigger_in   (trigger_in),
		.trigger_edge (trigger_edge)
	);

	// word issue and status, credits come back from the serializer
	pattern_sequencer pattern_sequencer_i (
		.clock         (clock),
		.core_reset    (core_reset),
		.trigger_edge  (trigger_edge),
		.self_trigger  (self_trigger),
		.credit_return (credit_return),
		.word_valid    (word_valid),
		.sync          (sync),
		.word_data     (word_data),
		.status_word   (status_word),
		.missed_count  (missed_count)
	);

	word_serializer word_serializer_i (
		.clock         (clock),
		.core_reset    (core_reset),
		.word_valid    (word_valid),
		.word_data     (word_data),
		.credit_return (credit_return),
		.serial_out    (serial_out),
		.frame_mark    (frame_mark)
	);

endmodule

/* dv/trigger_pattern_tb.sv */
`timescale 1ns/100ps

module trigger_pattern_tb;
	import trig_pkg::*;

	localparam int clock_period = 20;
	localparam int reset_cycles = 5;
	localparam int wide_count   = 6;
	localparam int status_count = 4;
	localparam int burst_count  = 24;
	localparam int self_cycles  = 384;
	localparam int self_period  = 1 << self_period_log2;

	// watchdog fires after the summed cycle budgets of all tests
	localparam int budget_reset    = reset_cycles + reset_hold_cycles + 130;
	localparam int budget_wide     = (wide_count + status_count) * 80 + 400;
	localparam int budget_burst    = burst_count * 4 + 300;
	localparam int budget_self     = self_cycles + 60;
	localparam int watchdog_cycles = budget_reset + budget_wide + budget_burst
		+ budget_self + 500;

	logic                    clock;
	logic                    reset1;
	logic                    trigger_in;
	logic                    self_trigger;
	logic                    serial_out;
	logic                    frame_mark;
	logic [word_width-1:0]   status_word;
	logic                    sync;
	logic [missed_width-1:0] missed_count;

	integer seed        = 32'heb4a7a8d;
	int     cycle_count = 0;
	int     error_count = 0;
	int     tests_ok    = 0;
	int     tests_bad   = 0;
	int     frame_count = 0;

	// reference model state
	logic [word_width-1:0]   exp_words[$];
	int                      exp_cycles[$];
	int                      exp_index[$];
	int                      pending_frames[$];
	int                      last_frame_cycle = -1000;
	int                      next_index       = 0;
	logic [missed_width-1:0] model_missed     = '0;
	logic                    check_status     = 1'b0;
	logic                    self_mode        = 1'b0;
	int                      last_self_frame  = -1;
	int                      self_frames      = 0;

	trigger_pattern_top trigger_pattern_top_i (
		.clock        (clock),
		.reset1       (reset1),
		.trigger_in   (trigger_in),
		.self_trigger (self_trigger),
		.serial_out   (serial_out),
		.frame_mark   (frame_mark),
		.status_word  (status_word),
		.sync         (sync),
		.missed_count (missed_count)
	);

	always #(clock_period / 2) clock = ~clock;

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
	end

	// marker for a position in the rotation
	function automatic logic [word_width-1:0] marker_word(input int index);
		case (index % 4)
			0:       marker_word = 8'hf0;
			1:       marker_word = 8'h81;
			2:       marker_word = 8'h88;
			default: marker_word = 8'haa;
		endcase
	endfunction

	// issue or drop a trigger event seen by the sequencer in event_cycle
	task automatic predict_event(input int event_cycle);
		int frame_cycle;
		// a credit comes back with frame_mark and counts from the next cycle
		while (pending_frames.size() != 0 && pending_frames[0] < event_cycle) begin
			void'(pending_frames.pop_front());
		end
		if (pending_frames.size() < credit_depth) begin
			// word_valid one cycle on and the msb two cycles after that
			frame_cycle = event_cycle + 3;
			// queued frames follow back to back
			if (last_frame_cycle + word_width > frame_cycle) begin
				frame_cycle = last_frame_cycle + word_width;
			end
			last_frame_cycle = frame_cycle;
			pending_frames.push_back(frame_cycle);
			exp_words.push_back(marker_word(next_index));
			exp_cycles.push_back(frame_cycle);
			exp_index.push_back(next_index);
			next_index++;
		end else if (model_missed != 8'hff) begin
			model_missed = model_missed + 8'd1;
		end
	endtask

	// edge reaches the sequencer three cycles after the input rises
	task automatic pulse_trigger(input int high_cycles, input int low_cycles);
		@(posedge clock);
		#1;
		trigger_in = 1'b1;
		predict_event(cycle_count + 3);
		repeat (high_cycles) @(posedge clock);
		#1;
		trigger_in = 1'b0;
		repeat (low_cycles - 1) @(posedge clock);
	endtask

	task automatic wait_for_frames(input int max_cycles);
		int waited;
		waited = 0;
		while (exp_words.size() != 0 && waited < max_cycles) begin
			@(posedge clock);
			waited++;
		end
		if (exp_words.size() != 0) begin
			$display("timeout: %0d expected frames never came out on serial_out",
				exp_words.size());
			error_count++;
			exp_words.delete();
			exp_cycles.delete();
			exp_index.delete();
		end
		repeat (4) @(posedge clock);
	endtask

	task automatic expect_byte(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected) begin
			$display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
			tests_ok++;
		end else begin
			$display("test %s: %0d errors", name, error_count - errors_before);
			tests_bad++;
		end
	endtask

	// each frame is 8 bits sent msb first from frame_mark on
	initial begin : capture_frames
		logic [word_width-1:0] frame_word;
		logic [word_width-1:0] status_seen;
		logic [word_width-1:0] expected;
		logic                  sync_seen;
		int                    start_cycle;
		int                    expected_cycle;
		int                    index;
		forever begin
			@(negedge clock);
			if (frame_mark === 1'b1) begin
				start_cycle = cycle_count;
				status_seen = status_word;
				sync_seen   = sync;
				frame_word[word_width-1] = serial_out;
				for (int bit_pos = word_width - 2; bit_pos >= 0; bit_pos--) begin
					@(negedge clock);
					frame_word[bit_pos] = serial_out;
				end
				if (self_mode) begin
					index = next_index;
					next_index++;
					if (last_self_frame >= 0 && start_cycle - last_self_frame != self_period) begin
						$display("Error: frame_mark spacing expected 0x%h actual 0x%h",
							self_period, start_cycle - last_self_frame);
						error_count++;
					end
					last_self_frame = start_cycle;
					self_frames++;
					expect_byte("serial_out word", frame_word, marker_word(index));
				end else if (exp_words.size() == 0) begin
					$display("frame on serial_out at cycle %0d with no word issued", start_cycle);
					error_count++;
				end else begin
					expected       = exp_words.pop_front();
					expected_cycle = exp_cycles.pop_front();
					index          = exp_index.pop_front();
					if (expected_cycle != start_cycle) begin
						$display("Error: frame_mark cycle expected 0x%h actual 0x%h",
							expected_cycle, start_cycle);
						error_count++;
					end
					expect_byte("serial_out word", frame_word, expected);
					if (check_status) begin
						expect_byte("status_word", status_seen, expected);
						if (sync_seen !== (index % 4 == 0)) begin
							$display("Error: sync expected 0x%h actual 0x%h",
								(index % 4 == 0), sync_seen);
							error_count++;
						end
					end
				end
				frame_count++;
			end
		end
	end

	initial begin : watchdog
		#(watchdog_cycles * clock_period);
		$display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
		$display("tests failed");
		$finish;
	end

	initial begin : run_tests
		int errors_before;
		int frames_before;
		int gap;
		clock        = 1'b0;
		reset1       = 1'b1;
		trigger_in   = 1'b0;
		self_trigger = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		#1;
		reset1 = 1'b0;
		repeat (reset_hold_cycles + 2) @(posedge clock);

		// idle outputs after reset
		errors_before = error_count;
		@(negedge clock);
		expect_byte("serial_out", {7'b0, serial_out}, 8'h00);
		expect_byte("frame_mark", {7'b0, frame_mark}, 8'h00);
		expect_byte("sync", {7'b0, sync}, 8'h00);
		expect_byte("status_word", status_word, 8'h00);
		expect_byte("missed_count", missed_count, 8'h00);
		frames_before = frame_count;
		repeat (100) @(posedge clock);
		if (frame_count != frames_before) begin
			$display("frame_mark appeared with no trigger applied");
			error_count++;
		end
		report_test("reset_idle", errors_before);

		// widely spaced external triggers wrap the rotation
		errors_before = error_count;
		frames_before = frame_count;
		for (int n = 0; n < wide_count; n++) begin
			gap = 30 + ($random(seed) & 31);
			pulse_trigger(6, gap);
		end
		wait_for_frames(100);
		if (frame_count - frames_before != wide_count) begin
			$display("expected %0d frames from external triggers, saw %0d",
				wide_count, frame_count - frames_before);
			error_count++;
		end
		report_test("external_rotation", errors_before);

		// sync and status checked at each frame start
		errors_before = error_count;
		check_status  = 1'b1;
		for (int n = 0; n < status_count; n++) begin
			gap = 30 + ($random(seed) & 31);
			pulse_trigger(6, gap);
		end
		wait_for_frames(100);
		check_status = 1'b0;
		report_test("sync_status", errors_before);

		// triggers faster than the serializer drains
		errors_before = error_count;
		for (int n = 0; n < burst_count; n++) begin
			pulse_trigger(2, 2);
		end
		wait_for_frames(200);
		expect_byte("missed_count", missed_count, model_missed);
		report_test("credit_burst", errors_before);

		// internal tick with external edges ignored
		errors_before = error_count;
		@(posedge clock);
		#1;
		self_trigger    = 1'b1;
		self_mode       = 1'b1;
		last_self_frame = -1;
		self_frames     = 0;
		for (int i = 0; i < self_cycles; i++) begin
			@(posedge clock);
			#1;
			trigger_in = (i % 6) < 3;
		end
		trigger_in = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		self_trigger = 1'b0;
		repeat (20) @(posedge clock);
		self_mode = 1'b0;
		if (self_frames < 5) begin
			$display("self trigger gave only %0d frames", self_frames);
			error_count++;
		end
		expect_byte("missed_count", missed_count, model_missed);
		report_test("self_trigger", errors_before);

		$display("%0d tests ok, %0d tests with errors, %0d errors",
			tests_ok, tests_bad, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* src.f */
logic/trig_pkg.sv
logic/power_on_reset.sv
logic/trigger_edge_detect.sv
logic/pattern_sequencer.sv
logic/word_serializer.sv
logic/trigger_pattern_top.sv
dv/trigger_pattern_tb.sv

/* Makefile */
# Verilator build and run for the trigger pattern generator
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= trigger_pattern_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= tests failed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

# a run fails when the log holds the fail message or the binary exits badly
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
